/* sr_chain_defines.svh */
/*
  Sideband serial register chain, build-time constants.
  Chain word length and the width of the frame counter
  that walks one frame of the master serializer.
*/
`ifndef SR_CHAIN_DEFINES_SVH
`define SR_CHAIN_DEFINES_SVH

// ==========================================================================
// Chain geometry
// ==========================================================================

`define SR_CHAIN_LEN 81 // Bits per chain word

// Counter reaches SR_CHAIN_LEN, so 7 bits cap the chain at 127
`define SR_CNT_W 7

`endif

/* sr_chain_pkg.sv */
/*
  Sideband serial register chain, shared types.
  Chain word, frame counter and the serializer phase
  used by the master end of the chain.
*/
`default_nettype none

`include "sr_chain_defines.svh"

package sr_chain_pkg;

  // ========================================================================
  // Data and counter vectors
  // ========================================================================
  typedef logic [`SR_CHAIN_LEN-1:0] sr_word_t; // One full chain word
  typedef logic [`SR_CNT_W-1:0]     sr_cnt_t;  // Frame position counter

  // ========================================================================
  // Serializer phase
  // ========================================================================
  typedef enum logic
  {
    SR_TX_SHIFT = 1'b0, // Shift toward top bit
    SR_TX_LOAD  = 1'b1  // Load strobe cycle
  } sr_tx_state_e;

endpackage

`default_nettype wire

/* sr_rst_sync.sv */
/*
  Reset synchronizer.
  Asserts asynchronously and releases after two edges of the
  destination clock. Scan mode hands the raw reset to the output
  so that ATPG drives it directly.
*/
`timescale 1ns/1ps
`default_nettype none

module sr_rst_sync
(
  input  logic clk,          // Destination clock
  input  logic reset_n_sync, // Raw reset, active low
  input  logic scan_mode,    // Bypass for ATPG
  output logic sync_reset_n  // Reset for clk domain
);

  logic [1:0] sync_ff; // Release pipeline

  always_ff @(posedge clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      sync_ff <= 2'b00;
    end
    else
    begin
      sync_ff <= {sync_ff[0], 1'b1}; // Ones walk in after release
    end
  end

  assign sync_reset_n = scan_mode ? reset_n_sync : sync_ff[1];

endmodule

`default_nettype wire

/* sr_bit_sync.sv */
/*
  Core word synchronizer.
  Every bit of the slowly changing core word passes through
  its own two-flop stage into the oscillator clock domain.
  A change on the input shows on the output two rising
  edges later.
*/
`timescale 1ns/1ps
`default_nettype none

module sr_bit_sync
  import sr_chain_pkg::*;
(
  input  logic     osc_clk,      // Oscillator clock
  input  logic     reset_n_sync, // Reset, active low
  input  sr_word_t data_in,      // Word from core domain
  output sr_word_t data_out      // Word in osc_clk domain
);

  // ==========================================================================
  // Two-stage register per bit
  // ==========================================================================

  sr_word_t meta_q; // First stage, may go metastable
  sr_word_t sync_q; // Second stage, settled value

  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      meta_q <= '0;
      sync_q <= '0;
    end
    else
    begin
      meta_q <= data_in;
      sync_q <= meta_q;
    end
  end

  // Bits are independent, so a word in transit may mix old and new bits.
  // The core holds the word for many frames, so this settles quickly.
  assign data_out = sync_q;

endmodule

`default_nettype wire

/* sr_ms_serializer.sv */
/*
  Master serializer.
  Repeats a frame of one load strobe followed by the chain
  word, most significant bit first. The frame counter sets
  the phase; outputs are retimed on the falling edge to give
  the receiver half a cycle of setup.
*/
`timescale 1ns/1ps
`default_nettype none

`include "sr_chain_defines.svh"

module sr_ms_serializer
  import sr_chain_pkg::*;
(
  input  logic     osc_clk,        // Oscillator clock
  input  logic     reset_n_sync,   // Reset, active low
  input  sr_word_t sync_word,      // Word already in osc_clk domain
  output logic     sr_ms_data_out, // Serial data to chain
  output logic     sr_ms_load_out  // Serial load strobe to chain
);

  sr_cnt_t      frame_cnt; // Position within frame
  sr_tx_state_e tx_state;  // Load or shift phase
  sr_word_t     shift_q;   // Parallel-load shift register
  logic         load_flag;

  // ==========================================================================
  // Frame counter and phase
  // ==========================================================================

  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      frame_cnt <= '0;
      tx_state  <= SR_TX_SHIFT;
    end
    else if (frame_cnt == sr_cnt_t'(`SR_CHAIN_LEN))
    begin
      frame_cnt <= '0;         // Wrap, frame is LEN+1 cycles
      tx_state  <= SR_TX_LOAD; // Strobe in the next cycle
    end
    else
    begin
      frame_cnt <= frame_cnt + sr_cnt_t'(1);
      tx_state  <= SR_TX_SHIFT;
    end
  end

  assign load_flag = (tx_state == SR_TX_LOAD);

  // ==========================================================================
  // Shift register
  // ==========================================================================

  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      shift_q <= '0;
    end
    else
    begin
      case (tx_state)
        SR_TX_LOAD:
        begin
          shift_q <= sync_word; // Fresh word at frame start
        end
        default:
        begin
          // Move toward top bit, bottom bit is kept
          shift_q <= {shift_q[`SR_CHAIN_LEN-2:0], shift_q[0]};
        end
      endcase
    end
  end

  // ==========================================================================
  // Falling-edge output stage
  // ==========================================================================

  always_ff @(negedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      sr_ms_data_out <= 1'b0;
      sr_ms_load_out <= 1'b0;
    end
    else
    begin
      sr_ms_data_out <= shift_q[`SR_CHAIN_LEN-1]; // MSB first
      sr_ms_load_out <= load_flag;
    end
  end

endmodule

`default_nettype wire

/* sr_ms_deserializer.sv */
/*
  Master deserializer.
  Shifts the incoming serial data in on the received clock.
  Each load strobe copies the receive register into the
  capture register, so the core sees the last complete word
  and it stays stable for a whole frame.
*/
`timescale 1ns/1ps
`default_nettype none

`include "sr_chain_defines.svh"

module sr_ms_deserializer
  import sr_chain_pkg::*;
(
  input  logic     sr_ms_clk_in,   // Incoming serial clock
  input  logic     rx_reset_n,     // Reset synced to sr_ms_clk_in
  input  logic     sr_ms_data_in,  // Serial data from chain
  input  logic     sr_ms_load_in,  // Serial load strobe from chain
  output sr_word_t ms_data_to_core // Captured word to core
);

  sr_word_t rx_shift_q; // Receive shift register

  // ==========================================================================
  // Receive shift register
  // ==========================================================================

  always_ff @(posedge sr_ms_clk_in or negedge rx_reset_n)
  begin
    if (!rx_reset_n)
    begin
      rx_shift_q <= '0;
    end
    else if (!sr_ms_load_in)
    begin
      // New bit enters at the bottom
      rx_shift_q <= {rx_shift_q[`SR_CHAIN_LEN-2:0], sr_ms_data_in};
    end
  end

  // ==========================================================================
  // Capture register
  // ==========================================================================

  always_ff @(posedge sr_ms_clk_in or negedge rx_reset_n)
  begin
    if (!rx_reset_n)
    begin
      ms_data_to_core <= '0;
    end
    else if (sr_ms_load_in)
    begin
      ms_data_to_core <= rx_shift_q; // Word of the previous frame
    end
  end

endmodule

`default_nettype wire

/* sr_chain_ms.sv */
/*
  Sideband serial register chain, master end.
  Brings the core word into the oscillator domain, sends it
  as a repeating serial frame, and returns the word received
  on the incoming serial clock to the core.
*/
`timescale 1ns/1ps
`default_nettype none

`include "sr_chain_defines.svh"

module sr_chain_ms
  import sr_chain_pkg::*;
(
  input  logic                     osc_clk,         // Free running oscillator clock
  input  logic                     reset_n_sync,    // Reset, synchronous to osc_clk
  input  logic                     atpg_mode,       // Scan bypass for receive reset
  input  logic [`SR_CHAIN_LEN-1:0] ms_data_fr_core, // Word from core
  output logic [`SR_CHAIN_LEN-1:0] ms_data_to_core, // Word to core
  output logic                     sr_ms_data_out,  // Serial data out
  output logic                     sr_ms_load_out,  // Serial load out
  input  logic                     sr_ms_data_in,   // Serial data in
  input  logic                     sr_ms_load_in,   // Serial load in
  input  logic                     sr_ms_clk_in     // Incoming serial clock
);

  sr_word_t sync_word;  // Core word in osc_clk domain
  logic     rx_reset_n; // Reset for sr_ms_clk_in domain

  // ==========================================================================
  // Input side
  // ==========================================================================

  sr_bit_sync u_bit_sync
  (
    .osc_clk      (osc_clk),
    .reset_n_sync (reset_n_sync),
    .data_in      (ms_data_fr_core),
    .data_out     (sync_word)
  );

  sr_rst_sync u_rx_rst_sync
  (
    .clk          (sr_ms_clk_in),
    .reset_n_sync (reset_n_sync),
    .scan_mode    (atpg_mode),
    .sync_reset_n (rx_reset_n)
  );

  // ==========================================================================
  // Transmit and receive paths
  // ==========================================================================

  sr_ms_serializer u_serializer
  (
    .osc_clk        (osc_clk),
    .reset_n_sync   (reset_n_sync),
    .sync_word      (sync_word),
    .sr_ms_data_out (sr_ms_data_out),
    .sr_ms_load_out (sr_ms_load_out)
  );

  sr_ms_deserializer u_deserializer
  (
    .sr_ms_clk_in    (sr_ms_clk_in),
    .rx_reset_n      (rx_reset_n),
    .sr_ms_data_in   (sr_ms_data_in),
    .sr_ms_load_in   (sr_ms_load_in),
    .ms_data_to_core (ms_data_to_core)
  );

endmodule

`default_nettype wire

/* tb_sr_chain_ms.sv */
/*
  Loopback testbench for the sideband serial chain master.
  Serial outputs feed the serial inputs and osc_clk doubles as
  the incoming serial clock. Words from a table are applied in
  turn, and the frame spacing, the bit order and the word
  returned to the core are checked against the frame rules.
*/
`timescale 1ns/1ps
`default_nettype none

`include "sr_chain_defines.svh"

module tb_sr_chain_ms
  import sr_chain_pkg::*;
();

  // ==========================================================================
  // Timing and table sizes
  // ==========================================================================

  localparam int HALF_PERIOD    = 20;
  localparam int DRIVE_DELAY    = 2;                // After rising edge
  localparam int RESET_CYCLES   = 5;
  localparam int LEN            = `SR_CHAIN_LEN;
  localparam int FRAME_CYCLES   = LEN + 1;          // Strobe plus LEN data bits
  localparam int FIRST_STROBE   = LEN + 2;          // Launched after edge LEN+1
  localparam int NUM_ENTRIES    = 8;
  localparam int ENTRY_FRAMES   = 3;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 4 * FRAME_CYCLES + 100;

  logic     osc_clk         = 1'b0;
  logic     reset_n_sync    = 1'b0;
  logic     atpg_mode       = 1'b0;
  sr_word_t ms_data_fr_core = '0;
  sr_word_t ms_data_to_core;
  logic     serial_data; // Loopback data
  logic     serial_load; // Loopback strobe

  sr_word_t word_tbl   [NUM_ENTRIES];
  string    name_tbl   [NUM_ENTRIES];
  int       frames_tbl [NUM_ENTRIES];

  int error_count  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_count  = 0;

  sr_chain_ms u_dut
  (
    .osc_clk         (osc_clk),
    .reset_n_sync    (reset_n_sync),
    .atpg_mode       (atpg_mode),
    .ms_data_fr_core (ms_data_fr_core),
    .ms_data_to_core (ms_data_to_core),
    .sr_ms_data_out  (serial_data),
    .sr_ms_load_out  (serial_load),
    .sr_ms_data_in   (serial_data),
    .sr_ms_load_in   (serial_load),
    .sr_ms_clk_in    (osc_clk)
  );

  always #(HALF_PERIOD) osc_clk = ~osc_clk;

  always @(posedge osc_clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic check_value(input string name, input sr_word_t expected,
                             input sr_word_t actual);
    if (expected !== actual)
    begin
      $display("Mismatch at %0t ns: %s expected 0x%h, actual 0x%h",
               $time, name, expected, actual);
      error_count = error_count + 1;
    end
  endtask

  function automatic sr_word_t random_word();
    sr_word_t w;
    int       k;
    w = '0;
    for (k = 0; k < 3; k++)
    begin
      w = (w << 32) | sr_word_t'($urandom());
    end
    return w;
  endfunction

  function automatic sr_word_t alternating_word(input logic top_bit);
    sr_word_t w;
    logic     b;
    int       k;
    w = '0;
    b = top_bit;
    for (k = 0; k < LEN; k++)
    begin
      w = (w << 1) | sr_word_t'(b); // Top bit enters first
      b = ~b;
    end
    return w;
  endfunction

  task automatic fill_table();
    word_tbl[0] = '0;
    word_tbl[1] = '1;
    word_tbl[2] = alternating_word(1'b1);
    word_tbl[3] = alternating_word(1'b0);
    word_tbl[4] = sr_word_t'(1) << (LEN - 1);
    word_tbl[5] = sr_word_t'(1);
    word_tbl[6] = random_word();
    word_tbl[7] = random_word();
    name_tbl = '{"all zeros", "all ones", "alternating 10", "alternating 01",
                 "single top bit", "single bottom bit", "random fill A",
                 "random fill B"};
    for (int k = 0; k < NUM_ENTRIES; k++)
    begin
      frames_tbl[k] = ENTRY_FRAMES;
    end
  endtask

  // Runs from one strobe to the next; serial lines are sampled on the
  // rising edge, the core word on the falling edge in between
  task automatic collect_frame(input sr_word_t exp_core, output int gap,
                               output sr_word_t bits);
    logic seen;
    gap  = 0;
    bits = '0;
    seen = 1'b0;
    while (!seen)
    begin
      @(posedge osc_clk);
      gap = gap + 1;
      if (serial_load)
      begin
        seen = 1'b1;
      end
      else
      begin
        if (gap <= LEN)
        begin
          bits = bits | (sr_word_t'(serial_data) << (LEN - gap)); // MSB first
        end
        @(negedge osc_clk);
        check_value("ms_data_to_core", exp_core, ms_data_to_core);
      end
    end
  endtask

  task automatic startup_frame();
    int       gap;
    sr_word_t bits;
    @(negedge osc_clk);
    check_value("sr_ms_load_out", '0, sr_word_t'(serial_load));
    check_value("sr_ms_data_out", '0, sr_word_t'(serial_data));
    check_value("ms_data_to_core", '0, ms_data_to_core);
    collect_frame('0, gap, bits);
    check_value("first strobe edge", sr_word_t'(FIRST_STROBE), sr_word_t'(gap));
  endtask

  // Frame 0 still carries the old word, frame 1 the new one, and the
  // core sees the new word from the strobe that ends frame 1
  task automatic run_entry(input sr_word_t word, input sr_word_t prev, input int frames);
    int       f;
    int       gap;
    sr_word_t bits;
    ms_data_fr_core = word;
    for (f = 0; f < frames; f++)
    begin
      collect_frame((f < 2) ? prev : word, gap, bits);
      check_value("strobe spacing", sr_word_t'(FRAME_CYCLES), sr_word_t'(gap));
      check_value("sr_ms_data_out bits", (f == 0) ? prev : word, bits);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    if (error_count == errors_before)
    begin
      $display("[%0d] %s: passed", tests_run, name);
    end
    else
    begin
      tests_failed = tests_failed + 1;
      $display("[%0d] %s: FAILED with %0d errors", tests_run, name,
               error_count - errors_before);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    int unsigned seed_result;
    int          idx;
    int          errors_before;
    sr_word_t    prev_word;

    seed_result = $urandom(82);
    fill_table();

    errors_before = error_count;
    repeat (RESET_CYCLES)
    begin
      @(negedge osc_clk);
      #(DRIVE_DELAY); // Past the falling-edge output stage
      check_value("sr_ms_load_out", '0, sr_word_t'(serial_load));
      check_value("sr_ms_data_out", '0, sr_word_t'(serial_data));
      check_value("ms_data_to_core", '0, ms_data_to_core);
    end
    @(posedge osc_clk);
    #(DRIVE_DELAY);
    reset_n_sync = 1'b1;
    startup_frame();
    report_test("reset and first strobe", errors_before);

    prev_word = '0;
    for (idx = 0; idx < NUM_ENTRIES; idx++)
    begin
      errors_before = error_count;
      #(DRIVE_DELAY);
      run_entry(word_tbl[idx], prev_word, frames_tbl[idx]);
      prev_word = word_tbl[idx];
      report_test(name_tbl[idx], errors_before);
    end

    // Reset pulse in scan mode, then the last word once more
    errors_before = error_count;
    #(DRIVE_DELAY);
    check_value("ms_data_to_core", prev_word, ms_data_to_core);
    atpg_mode       = 1'b1;
    reset_n_sync    = 1'b0;
    ms_data_fr_core = '0;
    #1;
    check_value("ms_data_to_core", '0, ms_data_to_core);
    check_value("sr_ms_load_out", '0, sr_word_t'(serial_load));
    check_value("sr_ms_data_out", '0, sr_word_t'(serial_data));
    repeat (2) @(posedge osc_clk);
    #(DRIVE_DELAY);
    reset_n_sync = 1'b1;
    startup_frame();
    #(DRIVE_DELAY);
    atpg_mode = 1'b0;
    run_entry(prev_word, '0, ENTRY_FRAMES);
    #(DRIVE_DELAY);
    check_value("ms_data_to_core", prev_word, ms_data_to_core);
    report_test("scan reset and recovery", errors_before);

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
sr_chain_pkg.sv
sr_rst_sync.sv
sr_bit_sync.sv
sr_ms_serializer.sv
sr_ms_deserializer.sv
sr_chain_ms.sv
tb_sr_chain_ms.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_sr_chain_ms -f list.f -o tb_sr_chain_ms \
  && ./obj_dir/tb_sr_chain_ms | tee sim.log \
  && grep -q "Test completed successfully" sim.log \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
